// ==== tb.f ====
rv32i_pkg.sv
core_pkg.sv
iq_if.sv
fetch_decode.sv
instr_queue.sv
scoreboard.sv
regfile.sv
issue_stage.sv
alu_exec.sv
alu_core.sv
tb_alu_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_alu_core
./obj_dir/Vtb_alu_core 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
grep -q "Simulation PASSED" sim.log

// ==== tb_alu_core.sv ====
// alu core testbench
`timescale 1ns/1ps

module tb_alu_core
    import rv32i_pkg::*;
();

    localparam int    NPROG    = 300;
    localparam int    LIMIT    = 20 * NPROG + 100;
    localparam word_t RESET_PC = 32'h0000_0060;
    localparam word_t NOP_WORD = 32'h0000_0013;

    logic     clk = 1'b0;
    logic     rst;
    word_t    pc;
    logic     inst_read;
    word_t    inst_rdata;
    logic     inst_resp;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    instr_u      prog [NPROG];
    word_t       ref_regs [32];
    reg_idx_t    exp_rd [$];
    word_t       exp_data [$];
    logic [31:0] rnd_state;
    int          n_kept;
    int          n_retired;
    int          n_fetch;
    int          cycles;

    alu_core i_alu_core (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .inst_read  (inst_read),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run;
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, what, got, exp);
            abort_run;
        end
    endtask

    task automatic check_rd(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got x%0d, expected x%0d", $time, what, got, exp);
            abort_run;
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            abort_run;
        end
    endtask

    // architectural result of one instruction from the model registers
    function automatic word_t ref_result(input instr_u w);
        word_t      a;
        word_t      b;
        word_t      res;
        logic       alt;
        logic [4:0] sh;
        if (w.u.opcode == LUI) begin
            return {w.u.imm, 12'h000};
        end
        a = ref_regs[w.r.rs1];
        if (w.r.opcode == OP) begin
            b   = ref_regs[w.r.rs2];
            alt = w.r.funct7[5];
        end else begin
            b   = {{20{w.i.imm[11]}}, w.i.imm};
            // immediate form has SRAI but no subtract
            alt = (w.i.funct3 == 3'd5) && w.i.imm[10];
        end
        sh = b[4:0];
        case (w.r.funct3)
            3'd0:    res = alt ? a - b : a + b;
            3'd1:    res = a << sh;
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd5:    res = alt ? word_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic is_kept(input instr_u w);
        return (w.r.opcode == OP || w.r.opcode == OP_IMM || w.r.opcode == LUI)
               && w.r.rd != 5'd0;
    endfunction

    function automatic instr_u make_instr(input int k, input reg_idx_t prev_rd,
                                          input logic [31:0] r_kind,
                                          input logic [31:0] r_fld,
                                          input logic [31:0] r_imm);
        instr_u     w;
        logic [3:0] kind;
        logic [2:0] f3;
        logic       alt;
        kind  = r_kind[31:28];
        f3    = r_fld[26:24];
        alt   = r_fld[23];
        w.raw = '0;
        if (k < 31) begin
            // seed x1..x31 so no later read sees an unwritten register
            w.i.opcode = OP_IMM;
            w.i.rd     = reg_idx_t'(k + 1);
            w.i.imm    = r_imm[31:20];
        end else if (kind < 4'd6 || kind == 4'd13) begin
            w.r.opcode = OP;
            w.r.rd     = (kind == 4'd13) ? 5'd0 : r_fld[31:27];
            w.r.funct3 = f3;
            w.r.rs1    = r_fld[22] ? prev_rd : r_fld[20:16];
            w.r.rs2    = r_fld[21] ? prev_rd : r_fld[15:11];
            w.r.funct7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        end else if (kind < 4'd11) begin
            w.i.opcode = OP_IMM;
            w.i.rd     = r_fld[31:27];
            w.i.funct3 = f3;
            w.i.rs1    = r_fld[22] ? prev_rd : r_fld[20:16];
            case (f3)
                3'd1:    w.i.imm = {7'h00, r_imm[24:20]};
                3'd5:    w.i.imm = {alt ? 7'h20 : 7'h00, r_imm[24:20]};
                default: w.i.imm = r_imm[31:20];
            endcase
        end else if (kind < 4'd13) begin
            w.u.opcode = LUI;
            w.u.rd     = r_fld[31:27];
            w.u.imm    = r_imm[31:12];
        end else begin
            // load, store, branch and jal are not decoded
            w.raw = r_imm;
            case (r_kind[27:26])
                2'd0:    w.raw[6:0] = 7'b0000011;
                2'd1:    w.raw[6:0] = 7'b0100011;
                2'd2:    w.raw[6:0] = 7'b1100011;
                default: w.raw[6:0] = 7'b1101111;
            endcase
        end
        return w;
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if (idx >= 0 && idx < NPROG) begin
            return prog[idx].raw;
        end
        return NOP_WORD;
    endfunction

    // instruction memory, about 70% of cycles respond
    always @(negedge clk) begin
        rnd_state  = lcg_next(rnd_state);
        inst_resp  = rnd_state[31:24] < 8'd179;
        inst_rdata = fetch_word(pc);
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (inst_read && inst_resp) begin
                check_data(pc, RESET_PC + word_t'(4 * n_fetch), "pc at fetch");
                n_fetch++;
            end
            if (wb_valid) begin
                if (n_retired >= n_kept) begin
                    $display("unexpected retirement to x%0d after the last kept instruction",
                             wb_rd);
                    abort_run;
                end else begin
                    check_rd(wb_rd, exp_rd[n_retired], "wb_rd");
                    check_data(wb_data, exp_data[n_retired], "wb_data");
                    n_retired++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, n_retired, n_kept);
            abort_run;
        end
    end

    initial begin
        instr_u      w;
        word_t       data;
        reg_idx_t    prev_rd;
        logic [31:0] r_kind;
        logic [31:0] r_fld;
        logic [31:0] r_imm;
        int          k;
        rst        = 1'b1;
        inst_rdata = '0;
        inst_resp  = 1'b0;
        n_retired  = 0;
        n_fetch    = 0;
        cycles     = 0;
        rnd_state  = 32'h67bd_936f;
        prev_rd    = '0;
        for (k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
        // program and expected retirements in program order
        for (k = 0; k < NPROG; k++) begin
            rnd_state = lcg_next(rnd_state);
            r_kind    = rnd_state;
            rnd_state = lcg_next(rnd_state);
            r_fld     = rnd_state;
            rnd_state = lcg_next(rnd_state);
            r_imm     = rnd_state;
            w         = make_instr(k, prev_rd, r_kind, r_fld, r_imm);
            prog[k]   = w;
            if (is_kept(w)) begin
                data = ref_result(w);
                exp_rd.push_back(w.r.rd);
                exp_data.push_back(data);
                ref_regs[w.r.rd] = data;
                prev_rd          = w.r.rd;
            end
        end
        n_kept = exp_rd.size();

        repeat (8) begin
            @(negedge clk);
            check_bit(inst_read, 1'b0, "inst_read in reset");
            check_bit(wb_valid, 1'b0, "wb_valid in reset");
        end
        rst = 1'b0;
        // first cycle out of reset
        #1;
        check_bit(inst_read, 1'b0, "inst_read after reset");
        check_bit(wb_valid, 1'b0, "wb_valid after reset");
        check_data(pc, RESET_PC, "pc after reset");

        while (n_retired < n_kept) begin
            @(negedge clk);
        end
        // late or extra retirements would show up here
        repeat (40) @(negedge clk);
        if (n_retired == n_kept && n_fetch >= NPROG) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("retired %0d of %0d kept instructions after %0d fetches",
                     n_retired, n_kept, n_fetch);
            abort_run;
        end
    end

endmodule

// ==== alu_core.sv ====
// in-order alu core
`timescale 1ns/1ps

module alu_core
    import rv32i_pkg::*;
    import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0060,
    parameter int    IQ_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    output word_t    pc,
    output logic     inst_read,
    input  word_t    inst_rdata,
    input  logic     inst_resp,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    logic     ex_valid;
    reg_idx_t ex_rd;
    alu_fn_t  ex_fn;
    word_t    ex_opr1;
    word_t    ex_opr2;

    iq_if iq ();

    fetch_decode #(.RESET_PC(RESET_PC)) i_fetch_decode (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .inst_read  (inst_read),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .iq         (iq.producer)
    );

    instr_queue #(.IQ_DEPTH(IQ_DEPTH)) i_instr_queue (
        .clk (clk),
        .rst (rst),
        .iq  (iq.queue)
    );

    // writeback loops back to the register file and scoreboard
    issue_stage i_issue_stage (
        .clk      (clk),
        .rst      (rst),
        .iq       (iq.consumer),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .ex_fn    (ex_fn),
        .ex_opr1  (ex_opr1),
        .ex_opr2  (ex_opr2)
    );

    alu_exec i_alu_exec (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .ex_fn    (ex_fn),
        .ex_opr1  (ex_opr1),
        .ex_opr2  (ex_opr2),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// ==== alu_exec.sv ====
// alu and writeback register
`timescale 1ns/1ps

module alu_exec
    import rv32i_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ex_valid,
    input  reg_idx_t ex_rd,
    input  alu_fn_t  ex_fn,
    input  word_t    ex_opr1,
    input  word_t    ex_opr2,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    word_t      alu_res;
    logic [4:0] shamt;

    assign shamt = ex_opr2[4:0];

    always_comb begin
        case (ex_fn)
            ALU_ADD:  alu_res = ex_opr1 + ex_opr2;
            ALU_SUB:  alu_res = ex_opr1 - ex_opr2;
            ALU_SLL:  alu_res = ex_opr1 << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(ex_opr1) < $signed(ex_opr2)};
            ALU_SLTU: alu_res = {31'b0, ex_opr1 < ex_opr2};
            ALU_XOR:  alu_res = ex_opr1 ^ ex_opr2;
            ALU_SRL:  alu_res = ex_opr1 >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(ex_opr1) >>> shamt);
            ALU_OR:   alu_res = ex_opr1 | ex_opr2;
            ALU_AND:  alu_res = ex_opr1 & ex_opr2;
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd   <= ex_rd;
            wb_data <= alu_res;
        end
    end

endmodule

// ==== issue_stage.sv ====
// register read and issue
`timescale 1ns/1ps

module issue_stage
    import rv32i_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    iq_if.consumer   iq,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output logic     ex_valid,
    output reg_idx_t ex_rd,
    output alu_fn_t  ex_fn,
    output word_t    ex_opr1,
    output word_t    ex_opr2
);

    iq_item_t head;
    logic     ready;
    word_t    rs1_data;
    word_t    rs2_data;

    assign head   = iq.head;
    assign iq.pop = ~iq.empty & ready;

    scoreboard i_scoreboard (
        .clk      (clk),
        .rst      (rst),
        .rd       (head.rd),
        .rs1      (head.rs1),
        .rs2      (head.rs2),
        .has_rs1  (head.has_rs1),
        .has_rs2  (head.has_rs2),
        .issue    (iq.pop),
        .ready    (ready),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd)
    );

    regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (head.rs1),
        .rs2      (head.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= iq.pop;
        end
    end

    // LUI adds its immediate to zero
    always_ff @(posedge clk) begin
        if (iq.pop) begin
            ex_rd   <= head.rd;
            ex_fn   <= head.alu_fn;
            ex_opr1 <= head.zero_opr1 ? '0 : rs1_data;
            ex_opr2 <= head.use_imm ? head.imm : rs2_data;
        end
    end

endmodule

// ==== regfile.sv ====
// integer register file
`timescale 1ns/1ps

module regfile
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data
);

    word_t regs [32];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 writes are dropped at decode
    assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != '0);

endmodule

// ==== scoreboard.sv ====
// register scoreboard
`timescale 1ns/1ps

module scoreboard
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     has_rs1,
    input  logic     has_rs2,
    input  logic     issue,
    output logic     ready,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd
);

    logic [31:0] pending;

    // a pending rd blocks too, so writebacks to one register stay in order
    assign ready = ~(pending[rd] | (has_rs1 & pending[rs1]) | (has_rs2 & pending[rs2]));

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_rd] <= 1'b0;
            end
            // rd is free here, so wb_rd cannot equal it
            if (issue && rd != '0) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    // every writeback retires a register marked at issue
    assert property (@(posedge clk) disable iff (rst) wb_valid |-> pending[wb_rd]);

endmodule

// ==== instr_queue.sv ====
// instruction queue
`timescale 1ns/1ps

module instr_queue
    import core_pkg::*;
#(
    parameter int IQ_DEPTH = 8
) (
    input logic clk,
    input logic rst,
    iq_if.queue iq
);

    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = IQ_DEPTH[PTR_W:0];

    iq_item_t         mem [IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = iq.push & ~iq.full;
    assign do_pop  = iq.pop & ~iq.empty;

    assign iq.full  = count == FULL_COUNT;
    assign iq.empty = count == '0;
    assign iq.head  = mem[rd_ptr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= iq.item;
        end
    end

    assert property (@(posedge clk) disable iff (rst) iq.push |-> !iq.full);
    assert property (@(posedge clk) disable iff (rst) iq.pop |-> !iq.empty);

endmodule

// ==== fetch_decode.sv ====
// fetch and decode
`timescale 1ns/1ps

module fetch_decode
    import rv32i_pkg::*;
    import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0060
) (
    input  logic   clk,
    input  logic   rst,
    output word_t  pc,
    output logic   inst_read,
    input  word_t  inst_rdata,
    input  logic   inst_resp,
    iq_if.producer iq
);

    logic     fetch_en;
    logic     fetch_fire;
    logic     dec_valid;
    instr_u   dec_word;
    iq_item_t item;
    logic     is_nop;

    function automatic alu_fn_t alu_fn_of(input logic [2:0] funct3, input logic alt);
        alu_fn_t fn;
        case (funct3)
            3'b000:  fn = alt ? ALU_SUB : ALU_ADD;
            3'b001:  fn = ALU_SLL;
            3'b010:  fn = ALU_SLT;
            3'b011:  fn = ALU_SLTU;
            3'b100:  fn = ALU_XOR;
            3'b101:  fn = alt ? ALU_SRA : ALU_SRL;
            3'b110:  fn = ALU_OR;
            default: fn = ALU_AND;
        endcase
        return fn;
    endfunction

    // fetch_en keeps the port quiet for one cycle after reset
    assign inst_read  = fetch_en & ~iq.full;
    assign fetch_fire = inst_read & inst_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en  <= 1'b0;
            pc        <= RESET_PC;
            dec_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (fetch_fire) begin
                pc        <= pc + 32'd4;
                dec_valid <= 1'b1;
            end else if (dec_valid && (is_nop || !iq.full)) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            dec_word.raw <= inst_rdata;
        end
    end

    always_comb begin
        item   = '0;
        is_nop = 1'b1;
        case (dec_word.r.opcode)
            OP: begin
                item.rd      = dec_word.r.rd;
                item.rs1     = dec_word.r.rs1;
                item.rs2     = dec_word.r.rs2;
                item.has_rs1 = 1'b1;
                item.has_rs2 = 1'b1;
                item.alu_fn  = alu_fn_of(dec_word.r.funct3, dec_word.r.funct7[5]);
                is_nop       = dec_word.r.rd == '0;
            end
            OP_IMM: begin
                item.rd      = dec_word.i.rd;
                item.rs1     = dec_word.i.rs1;
                item.has_rs1 = 1'b1;
                item.use_imm = 1'b1;
                item.imm     = {{20{dec_word.i.imm[11]}}, dec_word.i.imm};
                // bit 30 only means SRAI, there is no SUBI
                item.alu_fn  = alu_fn_of(dec_word.i.funct3,
                                         dec_word.i.funct3 == 3'b101 && dec_word.i.imm[10]);
                is_nop       = dec_word.i.rd == '0;
            end
            LUI: begin
                item.rd        = dec_word.u.rd;
                item.use_imm   = 1'b1;
                item.zero_opr1 = 1'b1;
                item.imm       = {dec_word.u.imm, 12'b0};
                item.alu_fn    = ALU_ADD;
                is_nop         = dec_word.u.rd == '0;
            end
            default: ;
        endcase
    end

    // a held word waits here while the queue is full
    assign iq.push = dec_valid & ~is_nop & ~iq.full;
    assign iq.item = item;

    // a decoded item stays put until the queue takes it
    assert property (@(posedge clk) disable iff (rst)
        dec_valid && !is_nop && !iq.push |=> dec_valid && $stable(dec_word.raw));

endmodule

// ==== iq_if.sv ====
// instruction queue link
`timescale 1ns/1ps

interface iq_if
    import core_pkg::*;
();

    logic     push;
    logic     pop;
    logic     full;
    logic     empty;
    iq_item_t item;
    iq_item_t head;

    modport producer (output push, output item, input full);
    modport queue    (input push, input item, input pop, output full, output empty, output head);
    modport consumer (output pop, input empty, input head);

endinterface

// ==== core_pkg.sv ====
// core pipeline types
package core_pkg;
    import rv32i_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_fn_t;

    // decode to issue
    typedef struct packed {
        alu_fn_t  alu_fn;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     has_rs1;
        logic     has_rs2;
        logic     use_imm;
        logic     zero_opr1;
        word_t    imm;
    } iq_item_t;

endpackage

// ==== rv32i_pkg.sv ====
// rv32i instruction formats
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one fetched word, read by the format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
        word_t  raw;
    } instr_u;

endpackage
